//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
TOP        = tb_uart_rx_bank
FILELIST   = sim.f
OBJDIR     = obj_dir
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qFx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- sim.f
+incdir+src
src/uart_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/wb_rx_regs.sv
src/uart_rx_bank.sv
verification/tb_uart_rx_bank.sv

//--- src/baud_tick_gen.sv
`timescale 1ns/1ns

module baud_tick_gen #(
    parameter int clks_per_tick = 4
) (
    input  logic clk,
    input  logic rst,
    output logic tick
);
    localparam int CNT_W = (clks_per_tick > 1) ? $clog2(clks_per_tick) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(clks_per_tick - 1);

    logic [CNT_W-1:0] cnt;

    // down-counter, pulse on wrap.
    always_ff @(posedge clk) begin
        if (!rst) begin
            cnt  <= RELOAD;
            tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt  <= RELOAD;
            tick <= 1'b1;
        end else begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    tick_spacing: assert property (@(posedge clk) disable iff (!rst)
        ((clks_per_tick > 1) && tick) |=> !tick);

endmodule

//--- src/uart_defs.svh
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// --------------------
// receiver bank size.
`define UART_NUM_CH 4

// frame format.
`define UART_DATA_W 8
`define UART_OVERSAMPLE 16

// --------------------
// register map, word addresses.
`define UART_REG_STATUS 0
// channel n sits at this address plus n.
`define UART_REG_DATA0 1

`endif

//--- src/uart_pkg.sv
`include "uart_defs.svh"

package uart_pkg;

    // one received character, frame_err in the top bit.
    typedef struct packed {
        logic                    frame_err;
        logic [`UART_DATA_W-1:0] data;
    } rx_frame_t;

    // --------------------
    // wishbone classic, master to slave.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    // slave to master.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

endpackage

//--- src/uart_rx.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                tick,
    input  logic                rx,
    output uart_pkg::rx_frame_t frame,
    output logic                frame_valid
);
    localparam logic [3:0] MID_TICK  = 4'(`UART_OVERSAMPLE / 2 - 1);
    localparam logic [3:0] LAST_TICK = 4'(`UART_OVERSAMPLE - 1);
    localparam logic [2:0] LAST_BIT  = 3'(`UART_DATA_W - 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_START,
        ST_DATA,
        ST_STOP
    } rx_state_t;

    rx_state_t               state;
    logic                    rx_meta;
    logic                    rx_sync;
    logic                    armed;
    logic [3:0]              tick_cnt;
    logic [2:0]              bit_cnt;
    logic [`UART_DATA_W-1:0] shreg;

    // --------------------
    // two-flop synchronizer, idles high.
    always_ff @(posedge clk) begin
        if (!rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    // --------------------
    // receive FSM, advances on tick only.
    always_ff @(posedge clk) begin
        if (!rst) begin
            state    <= ST_IDLE;
            armed    <= 1'b0;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (tick) begin
            case (state)
                ST_IDLE: begin
                    tick_cnt <= '0;
                    if (rx_sync) begin
                        armed <= 1'b1;
                    end else if (armed) begin
                        state <= ST_START;
                    end
                end
                ST_START: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == MID_TICK) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // line back high means a glitch.
                        state    <= rx_sync ? ST_IDLE : ST_DATA;
                    end
                end
                ST_DATA: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == LAST_TICK) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT) begin
                            state <= ST_STOP;
                        end
                    end
                end
                ST_STOP: begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == LAST_TICK) begin
                        state <= ST_IDLE;
                        // low stop bit, wait for a high sample first.
                        armed <= rx_sync;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge clk) begin
        if (tick && (state == ST_DATA) && (tick_cnt == LAST_TICK)) begin
            shreg <= {rx_sync, shreg[`UART_DATA_W-1:1]};
        end
    end

    assign frame.data      = shreg;
    assign frame.frame_err = ~rx_sync;
    assign frame_valid     = tick && (state == ST_STOP) && (tick_cnt == LAST_TICK);

    valid_one_cycle: assert property (@(posedge clk) disable iff (!rst)
        frame_valid |=> !frame_valid);

endmodule

//--- src/uart_rx_bank.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module uart_rx_bank #(
    parameter int clks_per_tick = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`UART_NUM_CH-1:0] rx,
    input  uart_pkg::wb_req_t       wb_req,
    output uart_pkg::wb_rsp_t       wb_rsp
);
    import uart_pkg::*;

    logic                    tick;
    rx_frame_t               frame [`UART_NUM_CH];
    logic [`UART_NUM_CH-1:0] frame_valid;

    // --------------------
    // shared oversample tick.
    baud_tick_gen #(
        .clks_per_tick(clks_per_tick)
    ) u_tick (
        .clk (clk),
        .rst (rst),
        .tick(tick)
    );

    // one receiver per serial line.
    generate
        for (genvar ch = 0; ch < `UART_NUM_CH; ch++) begin : ch_gen
            uart_rx u_rx (
                .clk        (clk),
                .rst        (rst),
                .tick       (tick),
                .rx         (rx[ch]),
                .frame      (frame[ch]),
                .frame_valid(frame_valid[ch])
            );
        end
    endgenerate

    // --------------------
    // register block on the bus.
    wb_rx_regs u_regs (
        .clk        (clk),
        .rst        (rst),
        .frame      (frame),
        .frame_valid(frame_valid),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp)
    );

endmodule

//--- src/wb_rx_regs.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module wb_rx_regs (
    input  logic                    clk,
    input  logic                    rst,
    input  uart_pkg::rx_frame_t     frame [`UART_NUM_CH],
    input  logic [`UART_NUM_CH-1:0] frame_valid,
    input  uart_pkg::wb_req_t       wb_req,
    output uart_pkg::wb_rsp_t       wb_rsp
);
    import uart_pkg::*;

    localparam int NCH = `UART_NUM_CH;

    rx_frame_t      data_q [NCH];
    logic [NCH-1:0] valid;
    logic [NCH-1:0] overrun;
    logic [NCH-1:0] ferr;
    logic           req;
    logic           ack;
    logic           served;
    logic           status_hit;
    logic [NCH-1:0] data_hit;
    logic [NCH-1:0] rd_clr;
    logic           ovr_wr;
    logic [31:0]    rd_dat;

    // --------------------
    // bus handshake, one ack per strobe.
    assign req = wb_req.cyc && wb_req.stb;

    always_ff @(posedge clk) begin
        if (!rst) begin
            ack    <= 1'b0;
            served <= 1'b0;
        end else begin
            ack    <= req && !ack && !served;
            served <= req && (ack || served);
        end
    end

    // address decode.
    assign status_hit = (wb_req.adr == 4'(`UART_REG_STATUS));

    always_comb begin
        for (int n = 0; n < NCH; n++) begin
            data_hit[n] = (wb_req.adr == 4'(`UART_REG_DATA0 + n));
        end
    end

    // side effects land at the end of the ack cycle.
    assign rd_clr = (ack && !wb_req.we) ? (data_hit & valid) : '0;
    assign ovr_wr = ack && wb_req.we && status_hit;

    // --------------------
    // per-channel flags.
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid   <= '0;
            overrun <= '0;
            ferr    <= '0;
        end else begin
            for (int n = 0; n < NCH; n++) begin
                if (ovr_wr && wb_req.dat[NCH + n]) begin
                    overrun[n] <= 1'b0;
                end
                if (frame_valid[n]) begin
                    valid[n] <= 1'b1;
                    ferr[n]  <= frame[n].frame_err;
                    // unread byte gets replaced.
                    if (valid[n] && !rd_clr[n]) begin
                        overrun[n] <= 1'b1;
                    end
                end else if (rd_clr[n]) begin
                    valid[n] <= 1'b0;
                    ferr[n]  <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int n = 0; n < NCH; n++) begin
            if (frame_valid[n]) begin
                data_q[n] <= frame[n];
            end
        end
    end

    // read mux, unmapped bits are zero.
    always_comb begin
        rd_dat = '0;
        if (status_hit) begin
            rd_dat[3*NCH-1:0] = {ferr, overrun, valid};
        end
        for (int n = 0; n < NCH; n++) begin
            if (data_hit[n]) begin
                rd_dat[`UART_DATA_W:0] = data_q[n];
            end
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rd_dat;

    ack_single: assert property (@(posedge clk) disable iff (!rst)
        (ack && wb_req.stb) |=> !ack);

    ack_needs_cyc: assert property (@(posedge clk) disable iff (!rst)
        ack |-> wb_req.cyc);

endmodule

//--- verification/tb_uart_rx_bank.sv
`timescale 1ns/1ns
`include "uart_defs.svh"

module tb_uart_rx_bank;
    import uart_pkg::*;

    localparam int NCH          = `UART_NUM_CH;
    localparam int CLKS_PER_BIT = 4 * `UART_OVERSAMPLE;
    localparam int ACK_TIMEOUT  = 20;

    logic                                 clk;
    logic                                 rst;
    logic [NCH-1:0]                       rx;
    wb_req_t                              wb_req;
    wb_rsp_t                              wb_rsp;
    string                                test_name;
    int unsigned                          cycle = 0;
    logic [NCH-1:0][`UART_DATA_W-1:0]     bytes;

    uart_rx_bank #(.clks_per_tick(4)) u_uart_rx_bank (
        .clk   (clk),
        .rst   (rst),
        .rx    (rx),
        .wb_req(wb_req),
        .wb_rsp(wb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    // --------------------
    task automatic step_clk();
        @(posedge clk);
        #1;
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: %s, expected 0x%0h, actual 0x%0h",
                     test_name, what, expected, actual);
            abort_run();
        end
    endtask

    // register images from the register map.
    function automatic logic [31:0] status_word(input logic [NCH-1:0] valid,
                                                input logic [NCH-1:0] ovr,
                                                input logic [NCH-1:0] ferr);
        return {20'b0, ferr, ovr, valid};
    endfunction

    function automatic logic [31:0] data_word(input logic err,
                                              input logic [`UART_DATA_W-1:0] data);
        return {23'b0, err, data};
    endfunction

    // --------------------
    // serial frames on the masked lines, all in step.
    task automatic send_frames(input logic [NCH-1:0] mask,
                               input logic [NCH-1:0][`UART_DATA_W-1:0] data,
                               input logic bad_stop);
        logic [`UART_DATA_W+1:0] bits [NCH];
        for (int n = 0; n < NCH; n++) begin
            bits[n] = {~bad_stop, data[n], 1'b0};
        end
        for (int b = 0; b < `UART_DATA_W + 2; b++) begin
            for (int n = 0; n < NCH; n++) begin
                if (mask[n]) begin
                    rx[n] = bits[n][b];
                end
            end
            repeat (CLKS_PER_BIT) step_clk();
        end
        rx = rx | mask;
    endtask

    task automatic send_byte(input int ch, input logic [`UART_DATA_W-1:0] data,
                             input logic bad_stop);
        logic [NCH-1:0][`UART_DATA_W-1:0] frames;
        frames     = '0;
        frames[ch] = data;
        send_frames(NCH'(1) << ch, frames, bad_stop);
    endtask

    task automatic wb_cycle(input logic we, input logic [3:0] adr,
                            input logic [31:0] wdat, output logic [31:0] rdat);
        int waited;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        waited     = 0;
        do begin
            step_clk();
            waited++;
        end while (!wb_rsp.ack && waited < ACK_TIMEOUT);
        if (!wb_rsp.ack) begin
            $display("bus cycle to address %0d was never acknowledged", adr);
            abort_run();
        end else begin
            rdat = wb_rsp.dat;
            step_clk();
            wb_req = '0;
            step_clk();
        end
    endtask

    task automatic wb_read(input logic [3:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, '0, dat);
    endtask

    task automatic wb_write(input logic [3:0] adr, input logic [31:0] dat);
        logic [31:0] ignored;
        wb_cycle(1'b1, adr, dat, ignored);
    endtask

    task automatic wait_valid(input int ch);
        int unsigned start;
        logic [31:0] st;
        start = cycle;
        st    = '0;
        while (!st[ch] && (cycle - start) < 1000) begin
            wb_read(4'(`UART_REG_STATUS), st);
        end
        if (!st[ch]) begin
            $display("channel %0d never reported a received byte", ch);
            abort_run();
        end
    endtask

    task automatic read_data(input int ch, input logic err,
                             input logic [`UART_DATA_W-1:0] data);
        logic [31:0] dat;
        wb_read(4'(`UART_REG_DATA0 + ch), dat);
        check($sformatf("data register %0d", ch), data_word(err, data), dat);
    endtask

    task automatic expect_status(input string what, input logic [31:0] expected);
        logic [31:0] st;
        wb_read(4'(`UART_REG_STATUS), st);
        check(what, expected, st);
    endtask

    // --------------------
    task automatic test_reset_single();
        logic [`UART_DATA_W-1:0] b;
        test_name = "reset_single";
        b         = 8'($urandom);
        expect_status("status after reset", '0);
        send_byte(0, b, 1'b0);
        wait_valid(0);
        expect_status("status with byte", status_word(4'h1, 4'h0, 4'h0));
        read_data(0, 1'b0, b);
        expect_status("status after read", '0);
    endtask

    task automatic test_all_channels();
        logic [`UART_DATA_W-1:0] base;
        test_name = "all_channels";
        base      = 8'($urandom);
        for (int n = 0; n < NCH; n++) begin
            bytes[n] = base ^ 8'(n * 8'h35);
        end
        send_frames('1, bytes, 1'b0);
        for (int n = 0; n < NCH; n++) begin
            wait_valid(n);
        end
        expect_status("status all valid", status_word('1, '0, '0));
        for (int n = 0; n < NCH; n++) begin
            read_data(n, 1'b0, bytes[n]);
        end
    endtask

    task automatic test_framing();
        logic [`UART_DATA_W-1:0] b;
        test_name = "framing";
        b         = 8'($urandom);
        send_byte(1, b, 1'b1);
        wait_valid(1);
        expect_status("status framing", status_word(4'h2, 4'h0, 4'h2));
        read_data(1, 1'b1, b);
        expect_status("status after read", '0);
        b = ~b;
        send_byte(1, b, 1'b0);
        wait_valid(1);
        read_data(1, 1'b0, b);
    endtask

    task automatic test_overrun();
        logic [`UART_DATA_W-1:0] b;
        test_name = "overrun";
        b         = 8'($urandom);
        // first byte differs from the one that must survive.
        send_byte(2, ~b, 1'b0);
        wait_valid(2);
        send_byte(2, b, 1'b0);
        expect_status("status overrun", status_word(4'h4, 4'h4, 4'h0));
        read_data(2, 1'b0, b);
        expect_status("status after read", status_word(4'h0, 4'h4, 4'h0));
        wb_write(4'(`UART_REG_STATUS), 32'h40);
        expect_status("status after clear", '0);
    endtask

    task automatic test_glitch();
        logic [`UART_DATA_W-1:0] b;
        int unsigned             start;
        test_name = "glitch";
        rx[3]     = 1'b0;
        repeat (8) step_clk();
        rx[3] = 1'b1;
        start = cycle;
        while ((cycle - start) < 12 * CLKS_PER_BIT) begin
            expect_status("status after glitch", '0);
        end
        b = 8'($urandom);
        send_byte(3, b, 1'b0);
        wait_valid(3);
        read_data(3, 1'b0, b);
    endtask

    initial begin
        void'($urandom(32'h81ca_5a73));
        rst       = 1'b0;
        rx        = '1;
        wb_req    = '0;
        test_name = "none";
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;
        test_reset_single();
        test_all_channels();
        test_framing();
        test_overrun();
        test_glitch();
        $display("Finished with no errors");
        $finish;
    end

endmodule
